// File: all.f
hw/conv_pkg.sv
hw/stream_if.sv
hw/input_sequencer.sv
hw/kernel_store.sv
hw/line_window.sv
hw/mac_tree.sv
hw/conv_engine.sv
tests/conv_checker.sv
tests/tb_conv_engine.sv

// File: run_sim.sh
#!/bin/sh
# build the conv engine testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_conv_engine -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0

// File: tests/tb_conv_engine.sv
// testbench top with clock, reset, case table, four-phase driver and summary
`timescale 1ns/1ps

module tb_conv_engine;

  localparam int FILL_CONST = 0;
  localparam int FILL_RAMP  = 1;
  localparam int FILL_RAND  = 2;
  localparam int FILL_TAP   = 3;
  localparam int N_CASES    = 5;
  localparam int TIMEOUT    = 200;

  typedef struct {
    string name;
    int    w_fill;
    int    w_val;
    int    p_fill;
    int    p_val;
    int    exp_val;
  } case_t;

  logic            clk;
  logic            rst_n;
  logic            mode;
  logic            in_req;
  conv_pkg::word_t in_data;
  logic            in_ack;
  logic            out_valid;
  conv_pkg::word_t out_data;
  logic            done;

  // filter and image of the running case, read by the checker
  conv_pkg::word_t wt [conv_pkg::CHANNELS][conv_pkg::KSIZE][conv_pkg::KSIZE];
  conv_pkg::word_t px [conv_pkg::IMG_SIZE][conv_pkg::IMG_SIZE][conv_pkg::CHANNELS];
  string           case_name;
  conv_pkg::word_t exp_const;

  case_t cases [N_CASES];
  int    seed;
  int    hs_errors;
  int    count_errors;

  conv_engine i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .out_valid (out_valid),
    .out_data  (out_data),
    .done      (done)
  );

  conv_checker u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_data  (out_data),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // four-phase driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (in_ack !== level && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (in_ack !== level) begin
      $display("ERROR in_ack did not go to %0b within %0d cycles", level, TIMEOUT);
      hs_errors++;
    end
  endtask

  task automatic send_word(input conv_pkg::word_t value);
    if (in_ack !== 1'b0) begin
      $display("ERROR in_ack was already high before the request");
      hs_errors++;
    end
    in_data = value;
    in_req  = 1'b1;
    wait_ack(1'b1);
    in_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic fill_case(input case_t tc);
    for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
      for (int r = 0; r < conv_pkg::KSIZE; r++) begin
        for (int c = 0; c < conv_pkg::KSIZE; c++) begin
          case (tc.w_fill)
            FILL_RAND: wt[ch][r][c] = $random(seed);
            FILL_TAP:  wt[ch][r][c] = (ch == 2 && r == 1 && c == 1) ? 1 : 0;
            default:   wt[ch][r][c] = tc.w_val;
          endcase
        end
      end
    end
    for (int r = 0; r < conv_pkg::IMG_SIZE; r++) begin
      for (int c = 0; c < conv_pkg::IMG_SIZE; c++) begin
        for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
          case (tc.p_fill)
            FILL_RAMP: px[r][c][ch] = 4 * (8 * r + c) + ch;
            FILL_RAND: px[r][c][ch] = $random(seed);
            default:   px[r][c][ch] = tc.p_val;
          endcase
        end
      end
    end
  endtask

  // both sets go in [row][col][ch] order
  task automatic load_weights();
    mode = 1'b0;
    for (int r = 0; r < conv_pkg::KSIZE; r++) begin
      for (int c = 0; c < conv_pkg::KSIZE; c++) begin
        for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
          send_word(wt[ch][r][c]);
        end
      end
    end
  endtask

  task automatic stream_pixels();
    mode = 1'b1;
    for (int r = 0; r < conv_pkg::IMG_SIZE; r++) begin
      for (int c = 0; c < conv_pkg::IMG_SIZE; c++) begin
        for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
          send_word(px[r][c][ch]);
        end
      end
    end
  endtask

  task automatic wait_frame(input int target);
    int n;
    n = 0;
    while (u_chk.frames < target && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (u_chk.frames < target) begin
      $display("ERROR no done for case %s within %0d cycles", case_name, TIMEOUT);
      hs_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    mode         = 1'b0;
    in_req       = 1'b0;
    in_data      = '0;
    seed         = 32'h5893;
    hs_errors    = 0;
    count_errors = 0;
    case_name    = "reset";
    exp_const    = '0;

    cases[0] = '{"ones",       FILL_CONST,  1, FILL_CONST, 1,   36};
    cases[1] = '{"single_tap", FILL_TAP,    0, FILL_RAMP,  0,    0};
    cases[2] = '{"signed",     FILL_CONST, -3, FILL_CONST, 5, -540};
    cases[3] = '{"random",     FILL_RAND,   0, FILL_RAND,  0,    0};
    cases[4] = '{"reload",     FILL_RAND,   0, FILL_RAMP,  0,    0};

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (in_ack !== 1'b0) begin
      $display("ERROR in_ack is not low after reset");
      hs_errors++;
    end

    for (int i = 0; i < N_CASES; i++) begin
      case_name = cases[i].name;
      exp_const = cases[i].exp_val;
      fill_case(cases[i]);
      load_weights();
      stream_pixels();
      wait_frame(i + 1);
      if (u_chk.results != conv_pkg::RESULTS * (i + 1)) begin
        $display("FAIL %s expected %0d actual %0d", case_name,
                 conv_pkg::RESULTS * (i + 1), u_chk.results);
        count_errors++;
      end
    end

    repeat (5) @(posedge clk);
    $display("errors: results %0d, handshake %0d, counts %0d",
             u_chk.errors, hs_errors, count_errors);
    if (u_chk.errors + hs_errors + count_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/conv_checker.sv
// reference convolution model and result, count and done compare
`timescale 1ns/1ps

module conv_checker (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            out_valid,
  input  conv_pkg::word_t out_data,
  input  logic            done
);

  // position inside the frame, whole frames seen, all results seen
  int idx     = 0;
  int frames  = 0;
  int results = 0;
  int errors  = 0;

  // one output point, sum over ch, kr, kc with 32-bit wrap
  function automatic conv_pkg::word_t model(input int r, input int c);
    conv_pkg::word_t acc;
    acc = '0;
    for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
      for (int kr = 0; kr < conv_pkg::KSIZE; kr++) begin
        for (int kc = 0; kc < conv_pkg::KSIZE; kc++) begin
          acc = acc + tb_conv_engine.px[r+kr][c+kc][ch] * tb_conv_engine.wt[ch][kr][kc];
        end
      end
    end
    return acc;
  endfunction

  always @(posedge clk) begin : compare
    conv_pkg::word_t expv;
    if (rst_n && out_valid) begin
      // results come out row-major
      expv = model(idx / conv_pkg::OUT_SIZE, idx % conv_pkg::OUT_SIZE);
      if (out_data !== expv) begin
        $display("FAIL %s expected %0d actual %0d", tb_conv_engine.case_name, expv, out_data);
        errors++;
      end
      if (tb_conv_engine.exp_const != 0 && out_data !== tb_conv_engine.exp_const) begin
        $display("FAIL %s expected %0d actual %0d", tb_conv_engine.case_name,
                 tb_conv_engine.exp_const, out_data);
        errors++;
      end
      if (done !== (idx == conv_pkg::RESULTS - 1)) begin
        $display("ERROR done is %0b on result %0d of case %s", done, idx,
                 tb_conv_engine.case_name);
        errors++;
      end
      results++;
      if (idx == conv_pkg::RESULTS - 1) begin
        idx = 0;
        frames++;
      end else begin
        idx++;
      end
    end else if (rst_n && done) begin
      $display("ERROR done raised without a valid result");
      errors++;
    end
  end

endmodule

// File: hw/conv_engine.sv
// top level of the streaming 3x3 convolution engine
`timescale 1ns/1ps

module conv_engine (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            mode,
  input  logic            in_req,
  input  conv_pkg::word_t in_data,
  output logic            in_ack,
  output logic            out_valid,
  output conv_pkg::word_t out_data,
  output logic            done
);

  conv_pkg::kernel_t weights;
  conv_pkg::win_t    windows [conv_pkg::CHANNELS];

  stream_if u_stream ();

  // word receiver and position counters
  input_sequencer u_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .mode    (mode),
    .in_req  (in_req),
    .in_data (in_data),
    .in_ack  (in_ack),
    .stream  (u_stream)
  );

  kernel_store u_kern (
    .clk     (clk),
    .rst_n   (rst_n),
    .stream  (u_stream),
    .weights (weights)
  );

  ////////////////////////////////////////////////////////////////////////////
  // one window per input channel
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < conv_pkg::CHANNELS; g++) begin : g_lane
    line_window #(
      .LANE (g)
    ) u_win (
      .clk    (clk),
      .rst_n  (rst_n),
      .stream (u_stream),
      .window (windows[g])
    );
  end

  mac_tree u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .stream    (u_stream),
    .windows   (windows),
    .weights   (weights),
    .out_valid (out_valid),
    .out_data  (out_data),
    .done      (done)
  );

endmodule

// File: hw/mac_tree.sv
// pipelined 36-tap multiply and sum across channels, with valid and done
`timescale 1ns/1ps

module mac_tree (
  input  logic              clk,
  input  logic              rst_n,
  stream_if.dst             stream,
  input  conv_pkg::win_t    windows [conv_pkg::CHANNELS],
  input  conv_pkg::kernel_t weights,
  output logic              out_valid,
  output conv_pkg::word_t   out_data,
  output logic              done
);

  conv_pkg::word_t prod_q [conv_pkg::CHANNELS][conv_pkg::KSIZE][conv_pkg::KSIZE];
  conv_pkg::word_t sum_c;
  logic            valid_q;
  logic            last_q;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: products, low 32 bits kept
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (stream.fire) begin
      for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
        for (int r = 0; r < conv_pkg::KSIZE; r++) begin
          for (int c = 0; c < conv_pkg::KSIZE; c++) begin
            prod_q[ch][r][c] <= $signed(windows[ch][r][c]) * $signed(weights[ch][r][c]);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2: sum over taps and channels, wraps at 32 bits
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sum_c = '0;
    for (int ch = 0; ch < conv_pkg::CHANNELS; ch++) begin
      for (int r = 0; r < conv_pkg::KSIZE; r++) begin
        for (int c = 0; c < conv_pkg::KSIZE; c++) begin
          sum_c = sum_c + prod_q[ch][r][c];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_q) begin
      out_data <= sum_c;
    end
  end

  // valid and last follow the products, then the sum
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= 1'b0;
      last_q    <= 1'b0;
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      valid_q   <= stream.fire;
      last_q    <= stream.last;
      out_valid <= valid_q;
      done      <= valid_q && last_q;
    end
  end

endmodule

// File: hw/line_window.sv
// per-channel line buffers and sliding 3x3 window
`timescale 1ns/1ps

module line_window #(
  parameter int LANE = 0
) (
  input  logic           clk,
  input  logic           rst_n,
  stream_if.dst          stream,
  output conv_pkg::win_t window
);

  // two rows up and one row up, indexed by column
  conv_pkg::word_t lb_top [conv_pkg::IMG_SIZE];
  conv_pkg::word_t lb_mid [conv_pkg::IMG_SIZE];

  conv_pkg::win_t  win_q;
  conv_pkg::win_t  win_next;
  logic            hit;

  assign hit = stream.load_px && (stream.ch == conv_pkg::ch_t'(LANE));

  // shift left, new column enters on the right
  always_comb begin
    win_next = win_q;
    for (int r = 0; r < conv_pkg::KSIZE; r++) begin
      for (int c = 0; c < conv_pkg::KSIZE - 1; c++) begin
        win_next[r][c] = win_q[r][c+1];
      end
    end
    win_next[0][conv_pkg::KSIZE-1] = lb_top[stream.col];
    win_next[1][conv_pkg::KSIZE-1] = lb_mid[stream.col];
    win_next[2][conv_pkg::KSIZE-1] = stream.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_q <= '0;
    end else if (hit) begin
      win_q <= win_next;
    end
  end

  // pixel moves down one line, displaced word moves to the top line
  always_ff @(posedge clk) begin
    if (hit) begin
      lb_top[stream.col] <= lb_mid[stream.col];
      lb_mid[stream.col] <= stream.data;
    end
  end

  // the last channel fires in its own load cycle, so show the updated
  // window while this lane is being loaded
  assign window = hit ? win_next : win_q;

endmodule

// File: hw/kernel_store.sv
// weight register array for the 4-channel 3x3 filter
`timescale 1ns/1ps

module kernel_store (
  input  logic              clk,
  input  logic              rst_n,
  stream_if.dst             stream,
  output conv_pkg::kernel_t weights
);

  conv_pkg::kernel_t kern_q;

  // weights arrive [row][col][ch], stored [ch][row][col]
  // row and column stay below 3 in weight mode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kern_q <= '0;
    end else if (stream.load_w) begin
      kern_q[stream.ch][stream.row[1:0]][stream.col[1:0]] <= stream.data;
    end
  end

  // whole filter goes to the MAC tree in parallel
  assign weights = kern_q;

endmodule

// File: hw/input_sequencer.sv
// four-phase input receiver with row, column and channel counters
`timescale 1ns/1ps

module input_sequencer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            mode,
  input  logic            in_req,
  input  conv_pkg::word_t in_data,
  output logic            in_ack,
  stream_if.src           stream
);

  conv_pkg::pos_t row_cnt;
  conv_pkg::pos_t col_cnt;
  conv_pkg::ch_t  ch_cnt;
  conv_pkg::pos_t lim;
  logic           accept;
  logic           px_fire;
  logic           px_last;

  // take a word on the first edge with req high and ack still low
  assign accept = in_req && !in_ack;

  // kernel is 3x3, image is 8x8
  assign lim = mode ? conv_pkg::pos_t'(conv_pkg::IMG_SIZE - 1)
                    : conv_pkg::pos_t'(conv_pkg::KSIZE - 1);

  // full neighbourhood available once all channels of this pixel are in
  assign px_fire = mode
                && (ch_cnt == conv_pkg::ch_t'(conv_pkg::CHANNELS - 1))
                && (col_cnt >= conv_pkg::pos_t'(conv_pkg::KSIZE - 1))
                && (row_cnt >= conv_pkg::pos_t'(conv_pkg::KSIZE - 1));

  assign px_last = px_fire
                && (col_cnt == conv_pkg::pos_t'(conv_pkg::IMG_SIZE - 1))
                && (row_cnt == conv_pkg::pos_t'(conv_pkg::IMG_SIZE - 1));

  ////////////////////////////////////////////////////////////////////////////
  // handshake, counters and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack         <= 1'b0;
      row_cnt        <= '0;
      col_cnt        <= '0;
      ch_cnt         <= '0;
      stream.load_w  <= 1'b0;
      stream.load_px <= 1'b0;
      stream.fire    <= 1'b0;
      stream.last    <= 1'b0;
    end else begin
      stream.load_w  <= accept && !mode;
      stream.load_px <= accept && mode;
      stream.fire    <= accept && px_fire;
      stream.last    <= accept && px_last;

      if (accept) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end

      // channel fastest, then column, then row
      if (accept) begin
        if (ch_cnt == conv_pkg::ch_t'(conv_pkg::CHANNELS - 1)) begin
          ch_cnt <= '0;
          if (col_cnt == lim) begin
            col_cnt <= '0;
            if (row_cnt == lim) begin
              row_cnt <= '0;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end else begin
          ch_cnt <= ch_cnt + 1'b1;
        end
      end
    end
  end

  // word and its position, held with the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      stream.data <= in_data;
      stream.row  <= row_cnt;
      stream.col  <= col_cnt;
      stream.ch   <= ch_cnt;
    end
  end

endmodule

// File: hw/stream_if.sv
// interface for accepted words, their positions and the fire and last strobes
`timescale 1ns/1ps

interface stream_if;

  // one-cycle strobes, by input mode
  logic               load_w;
  logic               load_px;

  // the accepted word and where it sits in the set
  conv_pkg::word_t    data;
  conv_pkg::pos_t     row;
  conv_pkg::pos_t     col;
  conv_pkg::ch_t      ch;

  // last channel of a pixel that completes a 3x3 neighbourhood
  logic               fire;
  // fire of the final pixel in the frame
  logic               last;

  modport src (output load_w, load_px, data, row, col, ch, fire, last);
  modport dst (input  load_w, load_px, data, row, col, ch, fire, last);

endinterface

// File: hw/conv_pkg.sv
// sizes, word and index types, window and kernel types for the conv engine
package conv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W   = 32;
  localparam int IMG_SIZE = 8;
  localparam int CHANNELS = 4;
  localparam int KSIZE    = 3;

  // valid output positions per row and column
  localparam int OUT_SIZE = IMG_SIZE - KSIZE + 1;
  localparam int RESULTS  = OUT_SIZE * OUT_SIZE;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // every pixel, weight and result is one signed word
  typedef logic signed [DATA_W-1:0] word_t;

  // row or column index into the image
  typedef logic [2:0] pos_t;

  // input channel index
  typedef logic [1:0] ch_t;

  // one channel's 3x3 neighbourhood, [row][col], row 0 is the oldest
  typedef word_t [KSIZE-1:0][KSIZE-1:0] win_t;

  // whole filter, [ch][row][col]
  typedef word_t [CHANNELS-1:0][KSIZE-1:0][KSIZE-1:0] kernel_t;

endpackage
